/* vlog.f */
+incdir+hdl
hdl/alu_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu_exec.sv
hdl/hazard_unit.sv
hdl/alu_pipe_top.sv
verif/alu_pipe_assert.sv
verif/alu_pipe_tb.sv

/* verif/alu_pipe_tb.sv */
/* Random RV64I ALU stream checked against an ISA model in the testbench.
   Registers are drawn from x0..x7 so dependencies are frequent; stops at the first error. */
`timescale 1ns/1ps
`include "alu_pipe_macros.svh"

module alu_pipe_tb;
    import alu_pipe_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_RAND   = 600;
    localparam int NUM_INSTR  = 32 + 1 + NUM_RAND;

    logic    clk_i;
    logic    arst_i;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    instr_ready_o;
    logic    retire_valid_o;
    retire_t retire_o;
    logic    retire_ready_i;

    logic [31:0] lfsr_q;
    data_t       model_regs [0:31];
    retire_t     exp_q [$];
    bit          known_q [$];
    int          retired_count;
    string       current_test;
    bit          expect_zero;

    alu_pipe_top i_alu_pipe_top (
        .clk_i          (clk_i),
        .arst_i         (arst_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    bind alu_pipe_top alu_pipe_assert i_alu_pipe_assert (
        .clk_i          (clk_i),
        .arst_i         (arst_i),
        .instr_ready_o  (instr_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Stimulus helpers.
    // ------------------------------------------------------------------

    // Galois LFSR that is stepped once per bit returned.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic instr_t gen_instr();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        kind = 3'(rand_bits(3));
        rd   = 5'(rand_bits(3));
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        alt  = 1'(rand_bits(1));
        imm  = 12'(rand_bits(12));
        if (kind == 3'd7) begin
            // The LOAD opcode lies outside the supported set.
            return {imm, rs1, f3, rd, 7'b0000011};
        end else if (kind >= 3'd4) begin
            if (f3 == 3'b001) begin
                imm[11:6] = 6'b000000;
            end else if (f3 == 3'b101) begin
                imm[11:6] = alt ? 6'b010000 : 6'b000000;
            end
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        alt = alt && ((f3 == 3'b000) || (f3 == 3'b101));
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic pick_ready(input bit random_ready);
        if (!random_ready) begin
            return 1'b1;
        end
        return (rand_bits(2) != 32'd0);
    endfunction

    function automatic int pick_gap();
        if (rand_bits(2) == 32'd3) begin
            return int'(rand_bits(2));
        end
        return 0;
    endfunction

    // ------------------------------------------------------------------
    // Reference model and checks.
    // ------------------------------------------------------------------

    // Executes one accepted word at ISA level and queues its retire value.
    task automatic model_exec(input instr_t w);
        logic [6:0]                       opc;
        logic [2:0]                       f3;
        logic                             is_imm;
        logic                             legal;
        data_t                            a;
        data_t                            b;
        data_t                            res;
        logic signed [`ALU_PIPE_XLEN-1:0] sa;
        logic signed [`ALU_PIPE_XLEN-1:0] sb;
        retire_t                          exp;
        opc    = w[6:0];
        f3     = w[14:12];
        is_imm = (opc == 7'b0010011);
        a      = model_regs[w[19:15]];
        b      = is_imm ? {{(`ALU_PIPE_XLEN - 12){w[31]}}, w[31:20]} : model_regs[w[24:20]];
        sa     = a;
        sb     = b;
        legal  = 1'b0;
        if (opc == 7'b0110011) begin
            legal = (w[31:25] == 7'b0000000) ||
                    ((w[31:25] == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
        end else if (is_imm) begin
            legal = 1'b1;
            if (f3 == 3'b001) begin
                legal = (w[31:26] == 6'b000000);
            end else if (f3 == 3'b101) begin
                legal = (w[31:26] == 6'b000000) || (w[31:26] == 6'b010000);
            end
        end
        case (f3)
            3'b000:  res = (!is_imm && w[30]) ? a - b : a + b;
            3'b001:  res = a << b[5:0];
            3'b010:  res = (sa < sb) ? data_t'(1) : data_t'(0);
            3'b011:  res = (a < b) ? data_t'(1) : data_t'(0);
            3'b100:  res = a ^ b;
            3'b101: begin
                sa  = sa >>> b[5:0];
                res = w[30] ? data_t'(sa) : (a >> b[5:0]);
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        exp.rd_addr = w[11:7];
        exp.result  = res;
        exp.reg_we  = legal && (w[11:7] != 5'd0);
        if (exp.reg_we) begin
            model_regs[w[11:7]] = res;
        end
        exp_q.push_back(exp);
        known_q.push_back(legal);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after the first error.");
    endtask

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            fail_run($sformatf({"CHECK FAILED %s expected rd=x%0d result=%h we=%b",
                                " actual rd=x%0d result=%h we=%b"}, name, exp.rd_addr,
                               exp.result, exp.reg_we, act.rd_addr, act.result, act.reg_we));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Drives one clock cycle after the edge and judges handshakes at the falling edge.
    task automatic step_cycle(input logic valid, input instr_t word, input logic ready,
                              output bit accepted);
        retire_t exp;
        retire_t act;
        bit      known;
        @(posedge clk_i);
        #1;
        instr_valid_i  = valid;
        instr_i        = word;
        retire_ready_i = ready;
        @(negedge clk_i);
        if (i_alu_pipe_top.i_alu_pipe_assert.assert_errors != 0) begin
            fail_run("A protocol assertion on the DUT failed.");
        end
        accepted = instr_valid_i && instr_ready_o;
        if (retire_valid_o && retire_ready_i) begin
            if (exp_q.size() == 0) begin
                fail_run("The DUT retired a result with no instruction outstanding.");
            end
            exp   = exp_q.pop_front();
            known = known_q.pop_front();
            act   = retire_o;
            if (expect_zero) begin
                check_data(current_test, '0, act.result);
            end
            // Unsupported words leave the result undefined.
            if (!known) begin
                exp.result = '0;
                act.result = '0;
            end
            check_retire(current_test, exp, act);
            retired_count++;
        end
        if (accepted) begin
            model_exec(word);
        end
    endtask

    // Holds the word on the bus until it is taken.
    task automatic send_word(input instr_t w, input int gap, input bit random_ready);
        bit accepted;
        for (int i = 0; i < gap; i++) begin
            step_cycle(1'b0, '0, pick_ready(random_ready), accepted);
        end
        accepted = 1'b0;
        while (!accepted) begin
            step_cycle(1'b1, w, pick_ready(random_ready), accepted);
        end
    endtask

    task automatic drain(input bit random_ready);
        bit accepted;
        while (exp_q.size() != 0) begin
            step_cycle(1'b0, '0, pick_ready(random_ready), accepted);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------------
    initial begin
        bit     accepted;
        int     base;
        int     steps;
        int     gap;
        instr_t word;
        lfsr_q         = 32'h080f_f1d0;
        clk_i          = 1'b0;
        arst_i         = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        retire_ready_i = 1'b1;
        retired_count  = 0;
        expect_zero    = 1'b0;
        current_test   = "reset";
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        #1;
        arst_i = 1'b1;
        repeat (5) @(posedge clk_i);
        #1;
        arst_i = 1'b0;
        if ((retire_valid_o !== 1'b0) || (instr_ready_o !== 1'b1)) begin
            fail_run("The pipeline is not idle and ready after reset.");
        end

        // Every register reads zero after reset when copied by addi x1, xr, 0.
        current_test = "reset_reads";
        expect_zero  = 1'b1;
        for (int r = 0; r < 32; r++) begin
            send_word({12'h000, 5'(r), 3'b000, 5'd1, 7'b0010011}, 0, 1'b0);
        end
        drain(1'b0);
        expect_zero = 1'b0;

        current_test = "latency";
        base = retired_count;
        send_word({12'h123, 5'd0, 3'b000, 5'd2, 7'b0010011}, 0, 1'b0);
        steps = 0;
        while (retired_count == base) begin
            step_cycle(1'b0, '0, 1'b1, accepted);
            steps++;
        end
        check_data(current_test, data_t'(3), data_t'(steps));

        current_test = "fwd_chain";
        for (int i = 0; i < NUM_RAND / 2; i++) begin
            word = gen_instr();
            gap  = pick_gap();
            send_word(word, gap, 1'b0);
        end
        drain(1'b0);

        current_test = "backpressure";
        for (int i = 0; i < NUM_RAND / 2; i++) begin
            word = gen_instr();
            gap  = pick_gap();
            send_word(word, gap, 1'b1);
        end
        drain(1'b1);

        // Idle cycles catch a duplicated result at the tail of the stream.
        current_test = "tail";
        repeat (4) begin
            step_cycle(1'b0, '0, 1'b1, accepted);
        end

        if ((retire_valid_o !== 1'b0) || (instr_ready_o !== 1'b1)) begin
            fail_run("The pipeline is not idle and ready at the end of the run.");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // Generous bound of 20 cycles per instruction.
    initial begin
        #(NUM_INSTR * 20 * CLK_PERIOD);
        fail_run("Watchdog timeout, the run did not finish in time.");
    end

endmodule

/* verif/alu_pipe_assert.sv */
/* Handshake rules of alu_pipe_top, attached by bind. Each failure raises
   $error and counts in assert_errors, which the testbench polls. */
`timescale 1ns/1ps

module alu_pipe_assert (
    input logic                  clk_i,
    input logic                  arst_i,
    input logic                  instr_ready_o,
    input logic                  retire_valid_o,
    input alu_pipe_pkg::retire_t retire_o,
    input logic                  retire_ready_i
);

    int unsigned assert_errors = 0;

    // No result is offered in reset or on the first edge after it.
    reset_idle: assert property (@(posedge clk_i)
        (arst_i || $fell(arst_i)) |-> !retire_valid_o)
    else begin
        assert_errors++;
        $error("retire_valid_o is high during or right after reset");
    end

    // A stalled result stays offered and unchanged.
    retire_hold: assert property (@(posedge clk_i) disable iff (arst_i)
        (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_o)))
    else begin
        assert_errors++;
        $error("retire payload changed while the port was stalled");
    end

    // Input side accepts only while the whole pipe may advance.
    ready_rule: assert property (@(posedge clk_i) disable iff (arst_i)
        instr_ready_o == (!retire_valid_o || retire_ready_i))
    else begin
        assert_errors++;
        $error("instr_ready_o does not match the stall condition");
    end

endmodule

/* hdl/alu_pipe_top.sv */
/* RV64I ALU pipeline fed by a valid/ready instruction stream. A word taken
   on edge N is on the retire port after edge N+2 and retires on edge N+3. */
`timescale 1ns/1ps

module alu_pipe_top (
    input  logic                  clk_i,
    input  logic                  arst_i,
    input  logic                  instr_valid_i,
    input  alu_pipe_pkg::instr_t  instr_i,
    output logic                  instr_ready_o,
    output logic                  retire_valid_o,
    output alu_pipe_pkg::retire_t retire_o,
    input  logic                  retire_ready_i
);
    import alu_pipe_pkg::*;

    // ----------------------------------------------------------------------
    // Internal nets.
    // ----------------------------------------------------------------------
    logic        advance;
    logic        fwd_rs1;
    logic        fwd_rs2;
    logic        rf_we;

    logic        id_valid;
    logic        ex_valid;
    logic        wb_valid;
    id_payload_t id_d;
    id_payload_t id_q;
    ex_payload_t ex_d;
    ex_payload_t ex_q;
    wb_payload_t wb_d;
    wb_payload_t wb_q;

    // Decode outputs.
    reg_addr_t   dec_rs1_addr;
    reg_addr_t   dec_rs2_addr;
    reg_addr_t   dec_rd_addr;
    alu_op_e     dec_alu_op;
    logic        dec_use_imm;
    logic        dec_reg_we;
    data_t       dec_imm;
    data_t       rf_rs1_data;
    data_t       rf_rs2_data;

    // ----------------------------------------------------------------------
    // Decode stage.
    // ----------------------------------------------------------------------
    assign id_d.instr = instr_i;

    pipe_reg #(.payload_t(id_payload_t)) i_id_reg (
        .clk_i     (clk_i),
        .arst_i    (arst_i),
        .advance_i (advance),
        .valid_i   (instr_valid_i),
        .payload_i (id_d),
        .valid_o   (id_valid),
        .payload_o (id_q)
    );

    instr_decoder i_instr_decoder (
        .instr_i    (id_q.instr),
        .rs1_addr_o (dec_rs1_addr),
        .rs2_addr_o (dec_rs2_addr),
        .rd_addr_o  (dec_rd_addr),
        .alu_op_o   (dec_alu_op),
        .use_imm_o  (dec_use_imm),
        .reg_we_o   (dec_reg_we),
        .imm_o      (dec_imm)
    );

    // Writes happen on the retire handshake only.
    assign rf_we = wb_valid && retire_ready_i && wb_q.reg_we;

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .arst_i     (arst_i),
        .rs1_addr_i (dec_rs1_addr),
        .rs2_addr_i (dec_rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (wb_q.rd_addr),
        .rd_data_i  (wb_q.result)
    );

    assign ex_d = '{
        rs1_addr: dec_rs1_addr,
        rs2_addr: dec_rs2_addr,
        rs1_data: rf_rs1_data,
        rs2_data: rf_rs2_data,
        imm:      dec_imm,
        use_imm:  dec_use_imm,
        alu_op:   dec_alu_op,
        rd_addr:  dec_rd_addr,
        reg_we:   dec_reg_we
    };

    // ----------------------------------------------------------------------
    // Execute stage.
    // ----------------------------------------------------------------------
    pipe_reg #(.payload_t(ex_payload_t)) i_ex_reg (
        .clk_i     (clk_i),
        .arst_i    (arst_i),
        .advance_i (advance),
        .valid_i   (id_valid),
        .payload_i (ex_d),
        .valid_o   (ex_valid),
        .payload_o (ex_q)
    );

    alu_exec i_alu_exec (
        .ex_i       (ex_q),
        .fwd_rs1_i  (fwd_rs1),
        .fwd_rs2_i  (fwd_rs2),
        .fwd_data_i (wb_q.result),
        .wb_o       (wb_d)
    );

    // ----------------------------------------------------------------------
    // Write-back stage and control.
    // ----------------------------------------------------------------------
    pipe_reg #(.payload_t(wb_payload_t)) i_wb_reg (
        .clk_i     (clk_i),
        .arst_i    (arst_i),
        .advance_i (advance),
        .valid_i   (ex_valid),
        .payload_i (wb_d),
        .valid_o   (wb_valid),
        .payload_o (wb_q)
    );

    hazard_unit i_hazard_unit (
        .ex_valid_i     (ex_valid),
        .ex_rs1_i       (ex_q.rs1_addr),
        .ex_rs2_i       (ex_q.rs2_addr),
        .wb_valid_i     (wb_valid),
        .wb_rd_i        (wb_q.rd_addr),
        .wb_we_i        (wb_q.reg_we),
        .retire_ready_i (retire_ready_i),
        .advance_o      (advance),
        .fwd_rs1_o      (fwd_rs1),
        .fwd_rs2_o      (fwd_rs2)
    );

    // Ports.
    assign instr_ready_o  = advance;
    assign retire_valid_o = wb_valid;
    assign retire_o       = '{rd_addr: wb_q.rd_addr, result: wb_q.result, reg_we: wb_q.reg_we};

endmodule

/* hdl/hazard_unit.sv */
/* Pipeline-wide advance and write-back forwarding. There is no load, so
   the only stall source is a full write-back stage facing a busy retire port. */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                    ex_valid_i,
    input  alu_pipe_pkg::reg_addr_t ex_rs1_i,
    input  alu_pipe_pkg::reg_addr_t ex_rs2_i,
    input  logic                    wb_valid_i,
    input  alu_pipe_pkg::reg_addr_t wb_rd_i,
    input  logic                    wb_we_i,
    input  logic                    retire_ready_i,
    output logic                    advance_o,
    output logic                    fwd_rs1_o,
    output logic                    fwd_rs2_o
);

    logic wb_fwd_ok;

    // All stages move together when write-back can drain or is empty.
    assign advance_o = !wb_valid_i || retire_ready_i;

    // x0 is never a forwarding source.
    assign wb_fwd_ok = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    assign fwd_rs1_o = ex_valid_i && wb_fwd_ok && (ex_rs1_i == wb_rd_i);
    assign fwd_rs2_o = ex_valid_i && wb_fwd_ok && (ex_rs2_i == wb_rd_i);

endmodule

/* hdl/alu_exec.sv */
/* Execute stage ALU. Forwarded data comes only from write-back, which is
   the one stage ahead of execute. Shifts use the low log2(XLEN) bits. */
`timescale 1ns/1ps
`include "alu_pipe_macros.svh"

module alu_exec (
    input  alu_pipe_pkg::ex_payload_t ex_i,
    input  logic                      fwd_rs1_i,
    input  logic                      fwd_rs2_i,
    input  alu_pipe_pkg::data_t       fwd_data_i,
    output alu_pipe_pkg::wb_payload_t wb_o
);
    import alu_pipe_pkg::*;

    localparam int SHAMT_W = $clog2(`ALU_PIPE_XLEN);

    data_t              rs1_val;
    data_t              rs2_val;
    data_t              op_a;
    data_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    data_t              result;

    // ----------------------------------------------------------------------
    // Operand selection.
    // ----------------------------------------------------------------------
    assign rs1_val = fwd_rs1_i ? fwd_data_i : ex_i.rs1_data;
    assign rs2_val = fwd_rs2_i ? fwd_data_i : ex_i.rs2_data;

    assign op_a  = rs1_val;
    assign op_b  = ex_i.use_imm ? ex_i.imm : rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];

    // ----------------------------------------------------------------------
    // Operation.
    // ----------------------------------------------------------------------
    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = data_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = data_t'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = data_t'($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = '0;
        endcase
    end

    assign wb_o = '{rd_addr: ex_i.rd_addr, result: result, reg_we: ex_i.reg_we};

endmodule

/* hdl/reg_file.sv */
/* 32 x 64-bit register file, x0 hard-wired to zero. A write in the current
   cycle is bypassed to both read ports, so decode sees it at once. */
`timescale 1ns/1ps
`include "alu_pipe_macros.svh"

module reg_file (
    input  logic                    clk_i,
    input  logic                    arst_i,
    input  alu_pipe_pkg::reg_addr_t rs1_addr_i,
    input  alu_pipe_pkg::reg_addr_t rs2_addr_i,
    output alu_pipe_pkg::data_t     rs1_data_o,
    output alu_pipe_pkg::data_t     rs2_data_o,
    input  logic                    we_i,
    input  alu_pipe_pkg::reg_addr_t rd_addr_i,
    input  alu_pipe_pkg::data_t     rd_data_i
);
    import alu_pipe_pkg::*;

    localparam int NUM_REGS = 2 ** `ALU_PIPE_REG_ADDR_W;

    data_t regs_q [1:NUM_REGS-1];

    // Read with x0 and same-cycle write handling.
    function automatic data_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (rd_addr_i == addr)) begin
            return rd_data_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk_i or posedge arst_i) begin
        if (arst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

/* hdl/instr_decoder.sv */
/* Decodes RV64I OP and OP-IMM words only; the word forms (OP-32) are not handled.
   Any other opcode, a bad funct7 or rd of x0 gives reg_we_o low. */
`timescale 1ns/1ps
`include "alu_pipe_macros.svh"

module instr_decoder (
    input  alu_pipe_pkg::instr_t    instr_i,
    output alu_pipe_pkg::reg_addr_t rs1_addr_o,
    output alu_pipe_pkg::reg_addr_t rs2_addr_o,
    output alu_pipe_pkg::reg_addr_t rd_addr_o,
    output alu_pipe_pkg::alu_op_e   alu_op_o,
    output logic                    use_imm_o,
    output logic                    reg_we_o,
    output alu_pipe_pkg::data_t     imm_o
);
    import alu_pipe_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_op;
    logic       legal;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    // Sign-extended I-immediate; shifts use only its low six bits.
    assign imm_o = {{(`ALU_PIPE_XLEN - 12){instr_i[31]}}, instr_i[31:20]};

    // Bit 30 picks SUB and SRA; ADDI has no subtract form.
    assign alt_op = instr_i[30] && ((funct3 == 3'b101) ||
                                    ((opcode == OPC_OP) && (funct3 == 3'b000)));

    always_comb begin
        case (funct3)
            3'b000:  alu_op_o = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b011:  alu_op_o = ALU_SLTU;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
        endcase
    end

    always_comb begin
        use_imm_o = 1'b0;
        legal     = 1'b0;
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                // Shift immediates carry a six bit shamt under funct6.
                if (funct3 == 3'b001) begin
                    legal = (funct7[6:1] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
                end else begin
                    legal = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
    end

    assign reg_we_o = legal && (rd_addr_o != '0);

endmodule

/* hdl/pipe_reg.sv */
/* One pipeline stage register. Valid and payload load together on advance
   and hold otherwise; payload is only meaningful while valid_o is high. */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = alu_pipe_pkg::data_t
) (
    input  logic     clk_i,
    input  logic     arst_i,
    input  logic     advance_i,
    input  logic     valid_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    // Stage occupancy.
    always_ff @(posedge clk_i or posedge arst_i) begin
        if (arst_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    // Payload moves with the valid bit.
    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            payload_o <= payload_i;
        end
    end

endmodule

/* hdl/alu_pipe_pkg.sv */
/* Types shared by the ALU pipeline stages and the retire port.
   Stage payloads carry no valid bit; pipe_reg keeps it beside them. */
`include "alu_pipe_macros.svh"

package alu_pipe_pkg;

    // ------------------------------------------------------------------
    // Basic types.
    // ------------------------------------------------------------------
    typedef logic [`ALU_PIPE_XLEN-1:0]       data_t;
    typedef logic [`ALU_PIPE_INSTR_W-1:0]    instr_t;
    typedef logic [`ALU_PIPE_REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation selected by the decoder.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // ------------------------------------------------------------------
    // Stage payloads.
    // ------------------------------------------------------------------

    // Word waiting in the decode stage.
    typedef struct packed {
        instr_t instr;
    } id_payload_t;

    // Everything the execute stage needs, register data already read.
    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        data_t     rs1_data;
        data_t     rs2_data;
        data_t     imm;
        logic      use_imm;
        alu_op_e   alu_op;
        reg_addr_t rd_addr;
        logic      reg_we;
    } ex_payload_t;

    // Result waiting in write-back.
    typedef struct packed {
        reg_addr_t rd_addr;
        data_t     result;
        logic      reg_we;
    } wb_payload_t;

    // Retire port contents, same layout as the write-back payload.
    typedef struct packed {
        reg_addr_t rd_addr;
        data_t     result;
        logic      reg_we;
    } retire_t;

endpackage

/* hdl/alu_pipe_macros.svh */
/* Widths for the RV64I ALU pipeline. The package and the RTL assume XLEN 64
   and 32-bit words; other values are not supported by the decoder. */
`ifndef ALU_PIPE_MACROS_SVH
`define ALU_PIPE_MACROS_SVH

// ----------------------------------------------------------------------
// Data path widths.
// ----------------------------------------------------------------------

// Operand and result width.
`define ALU_PIPE_XLEN 64

// Instruction word width.
`define ALU_PIPE_INSTR_W 32

// Register index width, which gives 32 architectural registers.
`define ALU_PIPE_REG_ADDR_W 5

`endif
